/* hdl/back_end_pkg.sv */
package back_end_pkg;

    // Datapath and register file sizes
    localparam int DATA_W    = 16;
    localparam int NUM_PREGS = 16;
    localparam int NUM_AREGS = 8;
    localparam int ROB_DEPTH = 8;

    localparam int PREG_W    = $clog2(NUM_PREGS);
    localparam int AREG_W    = $clog2(NUM_AREGS);
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Kind of datapath inside an execution unit
    typedef enum logic {
        OP_ADD,
        OP_MUL
    } exec_op_e;

endpackage

/* hdl/exec_if.sv */
`timescale 1ns/10ps

// Writeback of one execution unit, read by register file and ROB
interface exec_if;

    logic                   valid;
    back_end_pkg::preg_t    tag_prf;    // Destination physical register
    back_end_pkg::rob_tag_t tag_rob;    // Entry to mark done
    back_end_pkg::data_t    result;

    modport unit (
        output valid,
        output tag_prf,
        output tag_rob,
        output result
    );

    modport sink (
        input  valid,
        input  tag_prf,
        input  tag_rob,
        input  result
    );

endinterface

/* hdl/prf.sv */
`timescale 1ns/10ps

module prf (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_issue,
    input  logic                    stop,
    output logic                    full_prf,
    output back_end_pkg::preg_t     tag_prf,

    input  back_end_pkg::preg_t     tag_ra_add,
    input  back_end_pkg::preg_t     tag_rb_add,
    input  back_end_pkg::preg_t     tag_ra_mul,
    input  back_end_pkg::preg_t     tag_rb_mul,

    output back_end_pkg::data_t     bus_a_add,
    output back_end_pkg::data_t     bus_b_add,
    output back_end_pkg::data_t     bus_a_mul,
    output back_end_pkg::data_t     bus_b_mul,

    exec_if.sink                    wb_add,
    exec_if.sink                    wb_mul,

    input  logic                    free_valid,
    input  back_end_pkg::preg_t     free_tag
);

    back_end_pkg::data_t                regs [back_end_pkg::NUM_PREGS];
    logic [back_end_pkg::NUM_PREGS-1:0] busy;
    logic                               alloc;

    assign alloc = valid_issue & ~stop;

    // Priority search, lowest free tag wins
    always_comb begin
        full_prf = 1'b1;
        tag_prf  = '0;
        for (int i = back_end_pkg::NUM_PREGS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                full_prf = 1'b0;
                tag_prf  = back_end_pkg::preg_t'(i);
            end
        end
    end

    // Operand read ports
    assign bus_a_add = regs[tag_ra_add];
    assign bus_b_add = regs[tag_rb_add];
    assign bus_a_mul = regs[tag_ra_mul];
    assign bus_b_mul = regs[tag_rb_mul];

    // Free list, the first NUM_AREGS tags back the committed map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < back_end_pkg::NUM_PREGS; i++) begin
                busy[i] <= (i < back_end_pkg::NUM_AREGS) ? 1'b1 : 1'b0;
            end
        end else begin
            if (free_valid) begin
                busy[free_tag] <= 1'b0;     // Old value retired
            end
            if (alloc) begin
                busy[tag_prf] <= 1'b1;
            end
        end
    end

    // Register i holds the value i out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < back_end_pkg::NUM_PREGS; i++) begin
                regs[i] <= back_end_pkg::data_t'(i);
            end
        end else begin
            if (wb_add.valid) begin
                regs[wb_add.tag_prf] <= wb_add.result;
            end
            if (wb_mul.valid) begin
                regs[wb_mul.tag_prf] <= wb_mul.result;
            end
        end
    end

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit #(
    parameter back_end_pkg::exec_op_e OP      = back_end_pkg::OP_ADD,
    parameter int                     LATENCY = 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  back_end_pkg::data_t     bus_a,
    input  back_end_pkg::data_t     bus_b,
    input  back_end_pkg::preg_t     tag_prf,
    input  back_end_pkg::rob_tag_t  tag_rob,
    exec_if.unit                    wb
);

    // Read-execute register
    logic                   rx_valid;
    back_end_pkg::data_t    rx_a;
    back_end_pkg::data_t    rx_b;
    back_end_pkg::preg_t    rx_tag_prf;
    back_end_pkg::rob_tag_t rx_tag_rob;

    back_end_pkg::data_t    alu_result;

    logic                   pipe_valid   [LATENCY];
    back_end_pkg::data_t    pipe_result  [LATENCY];
    back_end_pkg::preg_t    pipe_tag_prf [LATENCY];
    back_end_pkg::rob_tag_t pipe_tag_rob [LATENCY];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        rx_a       <= bus_a;
        rx_b       <= bus_b;
        rx_tag_prf <= tag_prf;
        rx_tag_rob <= tag_rob;
    end

    generate
        if (OP == back_end_pkg::OP_MUL) begin : g_mul
            assign alu_result = back_end_pkg::data_t'(rx_a * rx_b);    // Low half only
        end else begin : g_add
            assign alu_result = rx_a + rx_b;
        end
    endgenerate

    // One operation may enter every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < LATENCY; s++) begin
                pipe_valid[s] <= 1'b0;
            end
        end else begin
            pipe_valid[0] <= rx_valid;
            for (int s = 1; s < LATENCY; s++) begin
                pipe_valid[s] <= pipe_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe_result[0]  <= alu_result;
        pipe_tag_prf[0] <= rx_tag_prf;
        pipe_tag_rob[0] <= rx_tag_rob;
        for (int s = 1; s < LATENCY; s++) begin
            pipe_result[s]  <= pipe_result[s-1];
            pipe_tag_prf[s] <= pipe_tag_prf[s-1];
            pipe_tag_rob[s] <= pipe_tag_rob[s-1];
        end
    end

    assign wb.valid   = pipe_valid[LATENCY-1];
    assign wb.result  = pipe_result[LATENCY-1];
    assign wb.tag_prf = pipe_tag_prf[LATENCY-1];
    assign wb.tag_rob = pipe_tag_rob[LATENCY-1];

endmodule

/* hdl/rob.sv */
`timescale 1ns/10ps

module rob #(
    parameter int ROB_DEPTH = back_end_pkg::ROB_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_issue,
    output logic                    stop,
    output logic                    full_rob,
    input  logic                    full_prf,
    output back_end_pkg::rob_tag_t  tag_rob,

    input  back_end_pkg::areg_t     rw,
    input  back_end_pkg::preg_t     tag_prf,
    input  back_end_pkg::preg_t     tag_rw_old,

    exec_if.sink                    wb_add,
    exec_if.sink                    wb_mul,

    output logic                    retire,
    output back_end_pkg::areg_t     retire_rw,
    output back_end_pkg::preg_t     retire_tag,
    output back_end_pkg::preg_t     free_tag
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    back_end_pkg::areg_t    ent_rw      [ROB_DEPTH];
    back_end_pkg::preg_t    ent_tag     [ROB_DEPTH];
    back_end_pkg::preg_t    ent_tag_old [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]   ent_done;

    back_end_pkg::rob_tag_t head;
    back_end_pkg::rob_tag_t tail;
    logic [CNT_W-1:0]       count;
    logic                   issue;

    function automatic back_end_pkg::rob_tag_t ptr_next(input back_end_pkg::rob_tag_t ptr);
        if (ptr == back_end_pkg::rob_tag_t'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_rob = (count == CNT_W'(ROB_DEPTH));
    assign stop     = full_rob | full_prf;
    assign issue    = valid_issue & ~stop;
    assign tag_rob  = tail;

    // Oldest entry leaves once its result is back
    assign retire     = (count != '0) && ent_done[head];
    assign retire_rw  = ent_rw[head];
    assign retire_tag = ent_tag[head];
    assign free_tag   = ent_tag_old[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (issue) begin
                tail <= ptr_next(tail);
            end
            if (retire) begin
                head <= ptr_next(head);
            end
            case ({issue, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Completion flags, either unit can finish in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_done <= '0;
        end else begin
            if (issue) begin
                ent_done[tail] <= 1'b0;
            end
            if (wb_add.valid) begin
                ent_done[wb_add.tag_rob] <= 1'b1;
            end
            if (wb_mul.valid) begin
                ent_done[wb_mul.tag_rob] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ent_rw[tail]      <= rw;
            ent_tag[tail]     <= tag_prf;
            ent_tag_old[tail] <= tag_rw_old;   // Freed at retire
        end
    end

endmodule

/* hdl/arf.sv */
`timescale 1ns/10ps

// Committed rename map, one physical tag per architectural register
module arf (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    retire,
    input  back_end_pkg::areg_t     retire_rw,
    input  back_end_pkg::preg_t     retire_tag,
    output back_end_pkg::preg_t     arf_tag [back_end_pkg::NUM_AREGS]
);

    back_end_pkg::preg_t map_q [back_end_pkg::NUM_AREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < back_end_pkg::NUM_AREGS; r++) begin
                map_q[r] <= back_end_pkg::preg_t'(r);  // Identity mapping
            end
        end else if (retire) begin
            map_q[retire_rw] <= retire_tag;
        end
    end

    assign arf_tag = map_q;

endmodule

/* hdl/back_end.sv */
`timescale 1ns/10ps

module back_end (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    stop,
    input  logic                    valid_issue,
    output logic                    full_prf,
    output logic                    full_rob,
    output back_end_pkg::preg_t     tag_prf,
    output back_end_pkg::rob_tag_t  tag_rob,
    input  back_end_pkg::areg_t     rw,
    input  back_end_pkg::preg_t     tag_rw_old,

    input  logic                    valid_add,
    input  back_end_pkg::preg_t     tag_ra_add,
    input  back_end_pkg::preg_t     tag_rb_add,
    input  back_end_pkg::preg_t     tag_prf_add_in,
    input  back_end_pkg::rob_tag_t  tag_rob_add_in,
    input  logic                    valid_mul,
    input  back_end_pkg::preg_t     tag_ra_mul,
    input  back_end_pkg::preg_t     tag_rb_mul,
    input  back_end_pkg::preg_t     tag_prf_mul_in,
    input  back_end_pkg::rob_tag_t  tag_rob_mul_in,

    output logic                    valid_result_add,
    output back_end_pkg::preg_t     tag_prf_add,
    output back_end_pkg::data_t     result_add,
    output logic                    valid_result_mul,
    output back_end_pkg::preg_t     tag_prf_mul,
    output back_end_pkg::data_t     result_mul,

    output back_end_pkg::preg_t     arf_tag [back_end_pkg::NUM_AREGS]
);

    back_end_pkg::data_t    bus_a_add;
    back_end_pkg::data_t    bus_b_add;
    back_end_pkg::data_t    bus_a_mul;
    back_end_pkg::data_t    bus_b_mul;

    logic                   retire;
    back_end_pkg::areg_t    retire_rw;
    back_end_pkg::preg_t    retire_tag;
    back_end_pkg::preg_t    free_tag;

    exec_if wb_add ();
    exec_if wb_mul ();

    prf u_prf (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_issue    (valid_issue),
        .stop           (stop),
        .full_prf       (full_prf),
        .tag_prf        (tag_prf),
        .tag_ra_add     (tag_ra_add),
        .tag_rb_add     (tag_rb_add),
        .tag_ra_mul     (tag_ra_mul),
        .tag_rb_mul     (tag_rb_mul),
        .bus_a_add      (bus_a_add),
        .bus_b_add      (bus_b_add),
        .bus_a_mul      (bus_a_mul),
        .bus_b_mul      (bus_b_mul),
        .wb_add         (wb_add.sink),
        .wb_mul         (wb_mul.sink),
        .free_valid     (retire),
        .free_tag       (free_tag)
    );

    exec_unit #(
        .OP             (back_end_pkg::OP_ADD),
        .LATENCY        (1)
    ) u_add_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid          (valid_add),
        .bus_a          (bus_a_add),
        .bus_b          (bus_b_add),
        .tag_prf        (tag_prf_add_in),
        .tag_rob        (tag_rob_add_in),
        .wb             (wb_add.unit)
    );

    exec_unit #(
        .OP             (back_end_pkg::OP_MUL),
        .LATENCY        (3)
    ) u_mul_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid          (valid_mul),
        .bus_a          (bus_a_mul),
        .bus_b          (bus_b_mul),
        .tag_prf        (tag_prf_mul_in),
        .tag_rob        (tag_rob_mul_in),
        .wb             (wb_mul.unit)
    );

    rob #(
        .ROB_DEPTH      (back_end_pkg::ROB_DEPTH)
    ) u_rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_issue    (valid_issue),
        .stop           (stop),
        .full_rob       (full_rob),
        .full_prf       (full_prf),
        .tag_rob        (tag_rob),
        .rw             (rw),
        .tag_prf        (tag_prf),
        .tag_rw_old     (tag_rw_old),
        .wb_add         (wb_add.sink),
        .wb_mul         (wb_mul.sink),
        .retire         (retire),
        .retire_rw      (retire_rw),
        .retire_tag     (retire_tag),
        .free_tag       (free_tag)
    );

    arf u_arf (
        .clk            (clk),
        .rst_n          (rst_n),
        .retire         (retire),
        .retire_rw      (retire_rw),
        .retire_tag     (retire_tag),
        .arf_tag        (arf_tag)
    );

    // Writeback buses seen from outside
    assign valid_result_add = wb_add.valid;
    assign tag_prf_add      = wb_add.tag_prf;
    assign result_add       = wb_add.result;
    assign valid_result_mul = wb_mul.valid;
    assign tag_prf_mul      = wb_mul.tag_prf;
    assign result_mul       = wb_mul.result;

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD     = 100.0,
    parameter int  RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Release away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* dv/tb_back_end.sv */
`timescale 1ns/10ps

module tb_back_end;

    localparam int MAX_CYCLES = 2000;
    localparam int NP = back_end_pkg::NUM_PREGS;
    localparam int NA = back_end_pkg::NUM_AREGS;
    localparam int ND = back_end_pkg::ROB_DEPTH;

    typedef struct packed {
        int                     due;    // Model cycle in which valid is expected
        back_end_pkg::preg_t    tag;
        back_end_pkg::rob_tag_t rob;
        back_end_pkg::data_t    val;
    } wb_t;

    logic clk;
    logic rst_n;

    logic                   valid_issue;
    back_end_pkg::areg_t    rw;
    back_end_pkg::preg_t    tag_rw_old;
    logic                   valid_add;
    back_end_pkg::preg_t    tag_ra_add;
    back_end_pkg::preg_t    tag_rb_add;
    back_end_pkg::preg_t    tag_prf_add_in;
    back_end_pkg::rob_tag_t tag_rob_add_in;
    logic                   valid_mul;
    back_end_pkg::preg_t    tag_ra_mul;
    back_end_pkg::preg_t    tag_rb_mul;
    back_end_pkg::preg_t    tag_prf_mul_in;
    back_end_pkg::rob_tag_t tag_rob_mul_in;
    logic                   stop;
    logic                   full_prf;
    logic                   full_rob;
    back_end_pkg::preg_t    tag_prf;
    back_end_pkg::rob_tag_t tag_rob;
    logic                   valid_result_add;
    back_end_pkg::preg_t    tag_prf_add;
    back_end_pkg::data_t    result_add;
    logic                   valid_result_mul;
    back_end_pkg::preg_t    tag_prf_mul;
    back_end_pkg::data_t    result_mul;
    back_end_pkg::preg_t    arf_tag [NA];

    // Reference model
    back_end_pkg::data_t    m_val [NP];
    logic                   m_busy [NP];
    logic                   m_ready [NP];     // Written back, usable as a source
    back_end_pkg::preg_t    m_spec [NA];
    back_end_pkg::preg_t    m_com [NA];
    back_end_pkg::areg_t    r_rw [ND];
    back_end_pkg::preg_t    r_tag [ND];
    back_end_pkg::preg_t    r_old [ND];
    logic                   r_done [ND];
    int                     r_head;
    int                     r_tail;
    int                     r_cnt;
    wb_t                    add_q [$];
    wb_t                    mul_q [$];

    // Requests for the next drive edge
    logic                   req_issue;
    logic                   req_add;
    logic                   req_mul;
    int                     req_rw;
    int                     req_ra;
    int                     req_rb;
    int                     req_dst;
    int                     req_rob;

    int                     ncyc;
    int                     cyc_cnt;
    int                     errors;
    int                     mul_seen;
    int                     seed;

    tb_clk_gen i_tb_clk_gen (.clk(clk), .rst_n(rst_n));

    back_end i_back_end (.*);

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic int lowest_free();
        for (int i = 0; i < NP; i++) begin
            if (!m_busy[i]) return i;
        end
        return -1;
    endfunction

    function automatic logic model_stop();
        return (lowest_free() < 0) || (r_cnt == ND);
    endfunction

    function automatic int pick_ready();
        int t;
        t = $unsigned($random(seed)) % NP;
        for (int k = 0; k < NP; k++) begin
            if (m_ready[(t + k) % NP]) return (t + k) % NP;
        end
        return 0;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < NP; i++) begin
            m_val[i]   = i;
            m_busy[i]  = (i < NA);
            m_ready[i] = (i < NA);
        end
        for (int r = 0; r < NA; r++) begin
            m_spec[r] = r;
            m_com[r]  = r;
        end
        for (int e = 0; e < ND; e++) r_done[e] = 1'b0;
        r_head = 0;
        r_tail = 0;
        r_cnt  = 0;
        add_q.delete();
        mul_q.delete();
    endtask

    task automatic write_back(input wb_t e);
        m_val[e.tag]   = e.val;
        m_ready[e.tag] = 1'b1;
        r_done[e.rob]  = 1'b1;
    endtask

    // State change across one rising edge, from the inputs seen at that edge
    task automatic advance_model();
        int free_t;
        logic do_retire;
        logic do_issue;
        logic [2*back_end_pkg::DATA_W-1:0] prod;
        wb_t e;
        free_t    = lowest_free();
        do_retire = (r_cnt != 0) && r_done[r_head];
        do_issue  = valid_issue && !model_stop();
        if (valid_add) begin
            e = '{ncyc + 2, tag_prf_add_in, tag_rob_add_in, m_val[tag_ra_add] + m_val[tag_rb_add]};
            add_q.push_back(e);
        end
        if (valid_mul) begin
            prod = m_val[tag_ra_mul] * m_val[tag_rb_mul];
            e = '{ncyc + 4, tag_prf_mul_in, tag_rob_mul_in, prod[back_end_pkg::DATA_W-1:0]};
            mul_q.push_back(e);
        end
        if (add_q.size() > 0 && add_q[0].due == ncyc) write_back(add_q.pop_front());
        if (mul_q.size() > 0 && mul_q[0].due == ncyc) write_back(mul_q.pop_front());
        if (do_retire) begin
            m_com[r_rw[r_head]]   = r_tag[r_head];
            m_busy[r_old[r_head]] = 1'b0;
            r_head = (r_head + 1) % ND;
            r_cnt--;
        end
        if (do_issue) begin
            m_busy[free_t]  = 1'b1;
            m_ready[free_t] = 1'b0;
            m_spec[rw]      = free_t;
            r_rw[r_tail]    = rw;
            r_tag[r_tail]   = free_t;
            r_old[r_tail]   = tag_rw_old;
            r_done[r_tail]  = 1'b0;
            r_tail = (r_tail + 1) % ND;
            r_cnt++;
        end
        ncyc++;
    endtask

    task automatic compare_outputs();
        int free_t;
        logic exp_add;
        logic exp_mul;
        free_t  = lowest_free();
        exp_add = add_q.size() > 0 && add_q[0].due == ncyc;
        exp_mul = mul_q.size() > 0 && mul_q[0].due == ncyc;
        check_value("full_prf", full_prf, free_t < 0);
        check_value("full_rob", full_rob, r_cnt == ND);
        check_value("stop", stop, model_stop());
        if (free_t >= 0) check_value("tag_prf", tag_prf, free_t);
        check_value("tag_rob", tag_rob, r_tail);
        for (int r = 0; r < NA; r++) begin
            check_value($sformatf("arf_tag[%0d]", r), arf_tag[r], m_com[r]);
        end
        check_value("valid_result_add", valid_result_add, exp_add);
        if (exp_add && valid_result_add) begin
            check_value("tag_prf_add", tag_prf_add, add_q[0].tag);
            check_value("result_add", result_add, add_q[0].val);
        end
        check_value("valid_result_mul", valid_result_mul, exp_mul);
        if (exp_mul && valid_result_mul) begin
            check_value("tag_prf_mul", tag_prf_mul, mul_q[0].tag);
            check_value("result_mul", result_mul, mul_q[0].val);
            mul_seen++;
        end
    endtask

    task automatic cycle();
        @(posedge clk);
        advance_model();
        valid_issue    <= req_issue;
        rw             <= req_rw;
        tag_rw_old     <= m_spec[req_rw];   // Caller supplies the old mapping
        valid_add      <= req_add;
        tag_ra_add     <= req_ra;
        tag_rb_add     <= req_rb;
        tag_prf_add_in <= req_dst;
        tag_rob_add_in <= req_rob;
        valid_mul      <= req_mul;
        tag_ra_mul     <= req_ra;
        tag_rb_mul     <= req_rb;
        tag_prf_mul_in <= req_dst;
        tag_rob_mul_in <= req_rob;
        req_issue = 1'b0;
        req_add   = 1'b0;
        req_mul   = 1'b0;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic issue_instr(input int dst_rw, output int tag, output int rob_tag);
        int waited;
        waited = 0;
        while (model_stop() && waited < 50) begin
            cycle();
            waited++;
        end
        if (model_stop()) begin
            $display("Issue still blocked by stop after 50 cycles");
            errors++;
        end
        req_issue = 1'b1;
        req_rw    = dst_rw;
        cycle();
        // Taken on the next edge with the tags shown now
        tag     = lowest_free();
        rob_tag = r_tail;
        cycle();
    endtask

    task automatic exec_op(input logic is_mul, input int ra, input int rb, input int dst,
                           input int rob_tag);
        req_add = !is_mul;
        req_mul = is_mul;
        req_ra  = ra;
        req_rb  = rb;
        req_dst = dst;
        req_rob = rob_tag;
        cycle();
    endtask

    task automatic wait_result(input logic is_mul, output int edges);
        edges = 0;
        do begin
            cycle();
            edges++;
        end while (!(is_mul ? valid_result_mul : valid_result_add) && edges < 10);
        if (!(is_mul ? valid_result_mul : valid_result_add)) begin
            $display("No execution result within 10 cycles");
            errors++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((r_cnt != 0 || add_q.size() != 0 || mul_q.size() != 0) && n < 100) begin
            cycle();
            n++;
        end
        if (r_cnt != 0) begin
            $display("Reorder buffer did not empty within 100 cycles");
            errors++;
        end
    endtask

    task automatic check_reset_state();
        for (int r = 0; r < NA; r++) check_value("arf_tag after reset", arf_tag[r], r);
        check_value("tag_prf after reset", tag_prf, 8);
        check_value("tag_rob after reset", tag_rob, 0);
        check_value("full_prf after reset", full_prf, 0);
        check_value("full_rob after reset", full_rob, 0);
        check_value("stop after reset", stop, 0);
        check_value("valid_result_add after reset", valid_result_add, 0);
        check_value("valid_result_mul after reset", valid_result_mul, 0);
    endtask

    task automatic add_path();
        int tag;
        int rob_tag;
        int edges;
        issue_instr(1, tag, rob_tag);
        exec_op(1'b0, 2, 3, tag, rob_tag);
        wait_result(1'b0, edges);
        check_value("edges to add result", edges, 2);
        check_value("add result 2+3", result_add, 5);
        drain();
        check_value("arf_tag[1] after add", arf_tag[1], tag);
        check_value("freed tag reused", tag_prf, 1);
    endtask

    task automatic mul_pipeline();
        int tag [4];
        int rob_tag [4];
        int base;
        for (int i = 0; i < 4; i++) issue_instr(2 + i, tag[i], rob_tag[i]);
        base = mul_seen;
        for (int i = 0; i < 4; i++) exec_op(1'b1, i + 3, i + 4, tag[i], rob_tag[i]);
        drain();
        check_value("multiply results seen", mul_seen - base, 4);
    endtask

    task automatic out_of_order_retire();
        int mtag;
        int mrob;
        int atag;
        int arob;
        int mul_at;
        int add_at;
        int n;
        issue_instr(6, mtag, mrob);
        issue_instr(7, atag, arob);
        exec_op(1'b1, m_com[1], m_com[2], mtag, mrob);
        exec_op(1'b0, m_com[3], m_com[4], atag, arob);  // Finishes ahead of the multiply
        mul_at = -1;
        add_at = -1;
        n = 0;
        while ((mul_at < 0 || add_at < 0) && n < 20) begin
            cycle();
            n++;
            if (mul_at < 0 && arf_tag[6] == mtag) mul_at = n;
            if (add_at < 0 && arf_tag[7] == atag) add_at = n;
        end
        check_value("multiply committed", mul_at > 0, 1);
        check_value("add committed", add_at > 0, 1);
        check_value("multiply committed no later than add", mul_at <= add_at, 1);
        drain();
    endtask

    task automatic fill_until_stop();
        int tag [8];
        int rob_tag [8];
        int held_rob;
        int n;
        for (int i = 0; i < 8; i++) issue_instr(i, tag[i], rob_tag[i]);
        check_value("full_prf with eight issued", full_prf, 1);
        check_value("stop with eight issued", stop, 1);
        held_rob  = r_tail;
        req_issue = 1'b1;
        req_rw    = 0;
        cycle();
        cycle();
        check_value("full_prf after blocked issue", full_prf, 1);
        check_value("tag_rob after blocked issue", tag_rob, held_rob);
        exec_op(1'b0, m_com[0], m_com[1], tag[0], rob_tag[0]);
        n = 0;
        while (stop && n < 10) begin
            cycle();
            n++;
        end
        check_value("stop after one retire", stop, 0);
        for (int i = 1; i < 8; i++) exec_op(i % 2, m_com[1], m_com[2], tag[i], rob_tag[i]);
        drain();
    endtask

    task automatic random_mix();
        int tag;
        int rob_tag;
        int ra;
        int rb;
        logic is_mul;
        for (int i = 0; i < 60; i++) begin
            is_mul = $random(seed) & 1;
            issue_instr($unsigned($random(seed)) % NA, tag, rob_tag);
            ra = pick_ready();
            rb = pick_ready();
            exec_op(is_mul, ra, rb, tag, rob_tag);
        end
        drain();
    endtask

    initial begin
        cyc_cnt = 0;
        while (cyc_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cyc_cnt++;
        end
        $display("Run stopped at the limit of %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed           = 32'hc8d2_8f3b;
        errors         = 0;
        ncyc           = 0;
        mul_seen       = 0;
        valid_issue    = 1'b0;
        rw             = '0;
        tag_rw_old     = '0;
        valid_add      = 1'b0;
        tag_ra_add     = '0;
        tag_rb_add     = '0;
        tag_prf_add_in = '0;
        tag_rob_add_in = '0;
        valid_mul      = 1'b0;
        tag_ra_mul     = '0;
        tag_rb_mul     = '0;
        tag_prf_mul_in = '0;
        tag_rob_mul_in = '0;
        req_issue      = 1'b0;
        req_add        = 1'b0;
        req_mul        = 1'b0;
        req_rw         = 0;
        req_ra         = 0;
        req_rb         = 0;
        req_dst        = 0;
        req_rob        = 0;
        reset_model();
        @(posedge rst_n);
        check_reset_state();
        add_path();
        mul_pipeline();
        out_of_order_retire();
        fill_until_stop();
        random_mix();
        $display("All tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/back_end_pkg.sv
hdl/exec_if.sv
hdl/prf.sv
hdl/exec_unit.sv
hdl/rob.sv
hdl/arf.sv
hdl/back_end.sv
dv/tb_clk_gen.sv
dv/tb_back_end.sv

/* Bender.yml */
package:
  name: back_end

dependencies: {}

sources:
  - hdl/back_end_pkg.sv
  - hdl/exec_if.sv
  - hdl/prf.sv
  - hdl/exec_unit.sv
  - hdl/rob.sv
  - hdl/arf.sv
  - hdl/back_end.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_back_end.sv
